/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// first fetch address after reset
`define CPU_RESET_PC 32'h1c000000

// architectural register count, r0 included
`define CPU_NUM_REGS 32

// address window covered by the test program and its data
`define CPU_TEST_ADDR_LO 32'h1c000000
`define CPU_TEST_ADDR_HI 32'h1c00ffff

// SRAM models are indexed by word, so this is the depth they need
`define CPU_TEST_MEM_WORDS ((`CPU_TEST_ADDR_HI - `CPU_TEST_ADDR_LO + 1) >> 2)

`endif

/* cpu_pkg.sv */
package cpu_pkg;

    // widths with a meaning
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_en_t;

    // decoded operation
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_ADDI,
        OP_LU12I,
        OP_LOAD,
        OP_STORE,
        OP_BEQ,
        OP_BNE,
        OP_NONE
    } op_t;

    // fetch to execute, inst comes straight from the SRAM read data
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } fetch_to_ex_t;

    // execute to writeback
    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      rf_we;
        reg_addr_t rd;
        word_t     result;
        logic      is_load;
    } ex_to_wb_t;

    // pending register write, doubles as forwarding source
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } fwd_t;

    // branch outcome back to fetch
    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_t;

endpackage

/* fetch_stage.sv */
`timescale 1ns/1ps

`include "cpu_config.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  branch_t      redirect,
    output logic         inst_sram_en,
    output word_t        inst_sram_addr,
    input  word_t        inst_sram_rdata,
    output fetch_to_ex_t fetch_bus
);

    // address of the request whose data is on inst_sram_rdata now
    word_t pc;
    // a request went out last cycle
    logic  pending;
    word_t next_pc;
    logic  slot_valid;

    // the SRAM always answers, so fetch runs every cycle
    assign inst_sram_en = 1'b1;

    // redirect replaces the sequential address issued this cycle
    assign next_pc        = redirect.taken ? redirect.target : pc + 32'd4;
    assign inst_sram_addr = next_pc;

    // pc starts one word early so the first request is the reset PC
    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= `CPU_RESET_PC - 32'd4;
            pending <= 1'b0;
        end else begin
            pc      <= next_pc;
            pending <= inst_sram_en;
        end
    end

    // the word arriving now is the wrong-path slot when execute redirects,
    // so its valid bit is cleared on the way out
    assign slot_valid = pending & ~redirect.taken;

    assign fetch_bus = '{
        valid: slot_valid,
        pc:    pc,
        inst:  inst_sram_rdata
    };

    // branch targets come from execute, sequential ones from here
    a_fetch_aligned: assert property (
        @(posedge clk) disable iff (reset)
        inst_sram_en |-> (inst_sram_addr[1:0] == 2'b00)
    ) else $error("fetch address %h not word aligned", inst_sram_addr);

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  fetch_to_ex_t fetch_bus,
    output reg_addr_t    rf_raddr1,
    output reg_addr_t    rf_raddr2,
    input  word_t        rf_rdata1,
    input  word_t        rf_rdata2,
    input  fwd_t         wb_fwd,
    output branch_t      redirect,
    output logic         data_sram_en,
    output byte_en_t     data_sram_we,
    output word_t        data_sram_addr,
    output word_t        data_sram_wdata,
    output ex_to_wb_t    ex_bus
);

    fetch_to_ex_t ex_q;
    word_t        inst;
    reg_addr_t    rd;
    reg_addr_t    rj;
    reg_addr_t    rk;
    logic [11:0]  si12;
    logic [19:0]  si20;
    logic [15:0]  offs16;
    op_t          op;
    word_t        src1;
    word_t        src2;
    word_t        simm12;
    word_t        imm_sum;
    word_t        result;
    logic         writes_rd;
    logic         is_mem;
    logic         src_eq;

    // fetch to execute register
    always_ff @(posedge clk) begin
        ex_q <= fetch_bus;
        if (reset) begin
            ex_q.valid <= 1'b0;
        end
    end

    // instruction fields
    assign inst   = ex_q.inst;
    assign rd     = inst[4:0];
    assign rj     = inst[9:5];
    assign rk     = inst[14:10];
    assign si12   = inst[21:10];
    assign si20   = inst[24:5];
    assign offs16 = inst[25:10];

    always_comb begin
        op = OP_NONE;
        if (inst[31:15] == 17'h00020)
            op = OP_ADD;
        else if (inst[31:15] == 17'h00022)
            op = OP_SUB;
        else if (inst[31:15] == 17'h00029)
            op = OP_AND;
        else if (inst[31:15] == 17'h0002a)
            op = OP_OR;
        else if (inst[31:22] == 10'b0000001010)
            op = OP_ADDI;
        else if (inst[31:25] == 7'b0001010)
            op = OP_LU12I;
        else if (inst[31:22] == 10'b0010100010)
            op = OP_LOAD;
        else if (inst[31:22] == 10'b0010100110)
            op = OP_STORE;
        else if (inst[31:26] == 6'b010110)
            op = OP_BEQ;
        else if (inst[31:26] == 6'b010111)
            op = OP_BNE;
    end

    // stores and branches read rd as their second source
    assign rf_raddr1 = rj;
    assign rf_raddr2 = (op inside {OP_STORE, OP_BEQ, OP_BNE}) ? rd : rk;

    // writeback result wins over the register file
    assign src1 = (wb_fwd.we && wb_fwd.addr == rf_raddr1) ? wb_fwd.data : rf_rdata1;
    assign src2 = (wb_fwd.we && wb_fwd.addr == rf_raddr2) ? wb_fwd.data : rf_rdata2;

    // shared by addi.w and the memory address
    assign simm12  = {{20{si12[11]}}, si12};
    assign imm_sum = src1 + simm12;

    always_comb begin
        case (op)
            OP_ADD:   result = src1 + src2;
            OP_SUB:   result = src1 - src2;
            OP_AND:   result = src1 & src2;
            OP_OR:    result = src1 | src2;
            OP_ADDI:  result = imm_sum;
            OP_LU12I: result = {si20, 12'b0};
            default:  result = '0;
        endcase
    end

    // branch resolution
    assign src_eq          = (src1 == src2);
    assign redirect.taken  = ex_q.valid & (((op == OP_BEQ) & src_eq) | ((op == OP_BNE) & ~src_eq));
    assign redirect.target = ex_q.pc + {{14{offs16[15]}}, offs16, 2'b00};

    // data SRAM request
    assign is_mem          = (op == OP_LOAD) || (op == OP_STORE);
    assign data_sram_en    = ex_q.valid & is_mem;
    assign data_sram_we    = (ex_q.valid && op == OP_STORE) ? 4'hf : 4'h0;
    assign data_sram_addr  = imm_sum;
    assign data_sram_wdata = src2;

    assign writes_rd = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_LU12I, OP_LOAD};

    // r0 writes are dropped here
    assign ex_bus = '{
        valid:   ex_q.valid,
        pc:      ex_q.pc,
        rf_we:   writes_rd & (rd != 5'd0),
        rd:      rd,
        result:  result,
        is_load: op == OP_LOAD
    };

    // writes only ever go out with a request
    a_we_with_en: assert property (
        @(posedge clk) disable iff (reset)
        (data_sram_we != 4'h0) |-> data_sram_en
    ) else $error("data_sram_we %h without data_sram_en", data_sram_we);

endmodule

/* writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  ex_to_wb_t ex_bus,
    input  word_t     data_sram_rdata,
    output fwd_t      wb_fwd,
    output word_t     debug_wb_pc,
    output word_t     debug_wb_rf_wdata,
    output byte_en_t  debug_wb_rf_we,
    output reg_addr_t debug_wb_rf_wnum
);

    ex_to_wb_t wb_q;
    word_t     wb_data;
    logic      wb_we;

    // execute to writeback register
    always_ff @(posedge clk) begin
        wb_q <= ex_bus;
        if (reset) begin
            wb_q.valid <= 1'b0;
            wb_q.rf_we <= 1'b0;
        end
    end

    // load data shows up during this cycle
    assign wb_data = wb_q.is_load ? data_sram_rdata : wb_q.result;
    assign wb_we   = wb_q.valid & wb_q.rf_we;

    // register write, also seen by execute for forwarding
    assign wb_fwd = '{
        we:   wb_we,
        addr: wb_q.rd,
        data: wb_data
    };

    // trace mirrors the register write
    assign debug_wb_pc       = wb_q.pc;
    assign debug_wb_rf_we    = {4{wb_we}};
    assign debug_wb_rf_wnum  = wb_q.rd;
    assign debug_wb_rf_wdata = wb_data;

    // r0 suppression happens in execute
    a_no_r0_write: assert property (
        @(posedge clk) disable iff (reset)
        wb_fwd.we |-> (wb_fwd.addr != 5'd0)
    ) else $error("write to r0 signaled at pc %h", wb_q.pc);

endmodule

/* regfile.sv */
`timescale 1ns/1ps

`include "cpu_config.svh"

module regfile import cpu_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  fwd_t      wb_fwd
);

    word_t regs [`CPU_NUM_REGS];

    // single write port from writeback
    always_ff @(posedge clk) begin
        if (wb_fwd.we) begin
            regs[wb_fwd.addr] <= wb_fwd.data;
        end
    end

    // asynchronous reads, r0 is hardwired zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

/* cpu_core_top.sv */
`timescale 1ns/1ps

module cpu_core_top import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    // instruction SRAM
    output logic      inst_sram_en,
    output byte_en_t  inst_sram_we,
    output word_t     inst_sram_addr,
    output word_t     inst_sram_wdata,
    input  word_t     inst_sram_rdata,
    // data SRAM
    output logic      data_sram_en,
    output byte_en_t  data_sram_we,
    output word_t     data_sram_addr,
    output word_t     data_sram_wdata,
    input  word_t     data_sram_rdata,
    // write-back trace
    output word_t     debug_wb_pc,
    output byte_en_t  debug_wb_rf_we,
    output reg_addr_t debug_wb_rf_wnum,
    output word_t     debug_wb_rf_wdata
);

    fetch_to_ex_t fetch_bus;
    ex_to_wb_t    ex_bus;
    fwd_t         wb_fwd;
    branch_t      redirect;
    reg_addr_t    rf_raddr1;
    reg_addr_t    rf_raddr2;
    word_t        rf_rdata1;
    word_t        rf_rdata2;

    fetch_stage fetch_stage_i (
        .clk             (clk),
        .reset           (reset),
        .redirect        (redirect),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .fetch_bus       (fetch_bus)
    );

    execute_stage execute_stage_i (
        .clk             (clk),
        .reset           (reset),
        .fetch_bus       (fetch_bus),
        .rf_raddr1       (rf_raddr1),
        .rf_raddr2       (rf_raddr2),
        .rf_rdata1       (rf_rdata1),
        .rf_rdata2       (rf_rdata2),
        .wb_fwd          (wb_fwd),
        .redirect        (redirect),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .ex_bus          (ex_bus)
    );

    writeback_stage writeback_stage_i (
        .clk               (clk),
        .reset             (reset),
        .ex_bus            (ex_bus),
        .data_sram_rdata   (data_sram_rdata),
        .wb_fwd            (wb_fwd),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    regfile regfile_i (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wb_fwd (wb_fwd)
    );

    // instruction memory is read-only from the core
    assign inst_sram_we    = 4'h0;
    assign inst_sram_wdata = '0;

endmodule

/* trace_checker.sv */
`timescale 1ns/1ps

module trace_checker import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  byte_en_t  inst_sram_we,
    input  word_t     inst_sram_wdata,
    input  word_t     debug_wb_pc,
    input  byte_en_t  debug_wb_rf_we,
    input  reg_addr_t debug_wb_rf_wnum,
    input  word_t     debug_wb_rf_wdata,
    output logic      all_done,
    output int        current_test,
    output int        tests_passed,
    output int        tests_failed,
    output int        error_count
);

    localparam int MAX_RECORDS = 128;

    int    exp_test [MAX_RECORDS];
    word_t exp_pc   [MAX_RECORDS];
    word_t exp_num  [MAX_RECORDS];
    word_t exp_data [MAX_RECORDS];
    int    num_records;
    int    next_idx;
    int    test_errors;

    task automatic clear_records();
        num_records  = 0;
        next_idx     = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        error_count  = 0;
    endtask

    task automatic add_record(int test, word_t pc, word_t num, word_t data);
        if (num_records < MAX_RECORDS) begin
            exp_test[num_records] = test;
            exp_pc[num_records]   = pc;
            exp_num[num_records]  = num;
            exp_data[num_records] = data;
            num_records++;
        end else begin
            $display("Too many expected records, one of test %0d was dropped", test);
            error_count++;
        end
    endtask

    task automatic compare_field(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_retirement();
        int test;
        test = exp_test[next_idx];
        compare_field("debug_wb_pc", exp_pc[next_idx], debug_wb_pc);
        compare_field("debug_wb_rf_we", 32'hf, {28'h0, debug_wb_rf_we});
        compare_field("debug_wb_rf_wnum", exp_num[next_idx], {27'h0, debug_wb_rf_wnum});
        compare_field("debug_wb_rf_wdata", exp_data[next_idx], debug_wb_rf_wdata);
        next_idx++;
        // last record of this test
        if (next_idx == num_records || exp_test[next_idx] != test) begin
            if (test_errors == 0) begin
                $display("test %0d ok", test);
                tests_passed++;
            end else begin
                $display("test %0d bad, %0d errors", test, test_errors);
                tests_failed++;
            end
            error_count += test_errors;
            test_errors = 0;
        end
    endtask

    assign all_done     = (num_records > 0) && (next_idx == num_records);
    assign current_test = (next_idx < num_records) ? exp_test[next_idx] : 0;

    // trace settles well before the edge that ends the write-back cycle
    always @(posedge clk) begin
        if (!reset && debug_wb_rf_we != 4'h0) begin
            if (next_idx < num_records) begin
                check_retirement();
            end else begin
                $display("Unexpected retirement at %0t: pc %h wrote r%0d",
                         $time, debug_wb_pc, debug_wb_rf_wnum);
                error_count++;
            end
        end
    end

    // the core only ever reads instruction memory
    always @(posedge clk) begin
        if (!reset && inst_sram_we !== 4'h0) begin
            $display("Mismatch at %0t: inst_sram_we expected %h, got %h",
                     $time, 4'h0, inst_sram_we);
            error_count++;
        end
        if (!reset && inst_sram_wdata !== 32'h0) begin
            $display("Mismatch at %0t: inst_sram_wdata expected %h, got %h",
                     $time, 32'h0, inst_sram_wdata);
            error_count++;
        end
    end

endmodule

/* tb_cpu_core.sv */
`timescale 1ns/1ps

`include "cpu_config.svh"

module tb_cpu_core import cpu_pkg::*; ();

    localparam int IMAGE_WORDS  = 512;
    localparam int DRAIN_CYCLES = 20;

    logic      clk;
    logic      reset;
    logic      inst_sram_en;
    byte_en_t  inst_sram_we;
    word_t     inst_sram_addr;
    word_t     inst_sram_wdata;
    word_t     inst_sram_rdata;
    logic      data_sram_en;
    byte_en_t  data_sram_we;
    word_t     data_sram_addr;
    word_t     data_sram_wdata;
    word_t     data_sram_rdata;
    word_t     debug_wb_pc;
    byte_en_t  debug_wb_rf_we;
    reg_addr_t debug_wb_rf_wnum;
    word_t     debug_wb_rf_wdata;
    logic      all_done;
    int        current_test;
    int        tests_passed;
    int        tests_failed;
    int        error_count;

    word_t inst_mem [`CPU_TEST_MEM_WORDS];
    word_t data_mem [`CPU_TEST_MEM_WORDS];
    word_t image [IMAGE_WORDS];
    word_t inst_word;
    word_t data_word;
    int    inst_count;
    int    test_count;
    logic  load_error;
    logic  timed_out;

    cpu_core_top cpu_core_top_i (.*);

    trace_checker trace_checker_i (.*);

    always #4 clk = ~clk;

    // both SRAMs latch at the rising edge and present data at the falling one
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_word <= inst_mem[inst_sram_addr[15:2]];
        end
        if (data_sram_en) begin
            data_word <= data_mem[data_sram_addr[15:2]];
            for (int b = 0; b < 4; b++) begin
                if (data_sram_we[b]) begin
                    data_mem[data_sram_addr[15:2]][8*b +: 8] <= data_sram_wdata[8*b +: 8];
                end
            end
        end
    end

    always @(negedge clk) begin
        inst_sram_rdata <= inst_word;
        data_sram_rdata <= data_word;
    end

    task automatic fill_memories();
        word_t addr;
        for (int i = 0; i < `CPU_TEST_MEM_WORDS; i++) begin
            addr = `CPU_TEST_ADDR_LO + 4 * i;
            // top bits 111111 decode as no operation
            inst_mem[i] = addr ^ 32'he0000000;
            data_mem[i] = addr ^ 32'h5a5a5a5a;
        end
    endtask

    task automatic load_testdata();
        int    p;
        int    n;
        int    test_id;
        word_t addr;
        p = 0;
        test_id = 0;
        $readmemh("cpu_testdata.txt", image);
        while (p < IMAGE_WORDS && image[p] !== 32'h0 && !load_error) begin
            case (image[p])
                32'h1: begin
                    n = image[p + 2];
                    for (int i = 0; i < n; i++) begin
                        addr = image[p + 1] + 4 * i;
                        inst_mem[addr[15:2]] = image[p + 3 + i];
                    end
                    inst_count += n;
                    p += 3 + n;
                end
                32'h2: begin
                    addr = image[p + 1];
                    data_mem[addr[15:2]] = image[p + 2];
                    p += 3;
                end
                32'h3: begin
                    test_id = image[p + 1];
                    test_count++;
                    p += 2;
                end
                32'h4: begin
                    trace_checker_i.add_record(test_id, image[p + 1], image[p + 2], image[p + 3]);
                    p += 4;
                end
                default: begin
                    $display("Data file has unknown record tag %h at word %0d", image[p], p);
                    load_error = 1'b1;
                end
            endcase
        end
    endtask

    initial begin
        int limit;
        clk = 1'b0;
        reset = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        inst_count = 0;
        test_count = 0;
        load_error = 1'b0;
        timed_out = 1'b0;
        fill_memories();
        trace_checker_i.clear_records();
        load_testdata();
        limit = inst_count * 4 + 100;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // drain a few cycles after the last record to catch stray writes
        fork
            begin
                wait (all_done);
                repeat (DRAIN_CYCLES) @(posedge clk);
            end
            begin
                repeat (limit) @(posedge clk);
                timed_out = 1'b1;
            end
        join_any

        if (timed_out) begin
            $display("Timeout: test %0d did not finish within %0d cycles", current_test, limit);
        end
        $display("%0d of %0d tests passed, %0d with errors, %0d errors in total",
                 tests_passed, test_count, tests_failed, error_count);
        if (!timed_out && !load_error && error_count == 0 && test_count > 0 &&
            tests_passed == test_count) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* cpu_testdata.txt */
// tag 1 instruction block: start address, word count, words   tag 2 data word: address, value
// tag 3 test start: test number   tag 4 expected trace: pc, register, value   tag 0 end
3 1
// register and immediate arithmetic
1 1c000000 09
142468a1 0299e002 02bffc03 00100824 00110445
00149486 00150827 02800468 02a00029
4 1c000000 01 12345000  4 1c000004 02 00000678
4 1c000008 03 ffffffff  4 1c00000c 04 12345678
4 1c000010 05 edcbb678  4 1c000014 06 00001678
4 1c000018 07 12345678  4 1c00001c 08 00000000
4 1c000020 09 12344800
3 2
// back-to-back dependent chain
1 1c000024 06
0280140a 0010294a 0010294b 0011296c 00152d8d 028401ad
4 1c000024 0a 00000005  4 1c000028 0a 0000000a
4 1c00002c 0b 00000014  4 1c000030 0c 0000000a
4 1c000034 0d 0000001e  4 1c000038 0d 0000011e
3 3
// stores and loads, preloaded words first
2 1c001000 cafef00d
2 1c001004 0badc0de
1 1c00003c 09
1438002e 288001cf 00103df0 298021d0 288021d1
288011d2 298001d2 288001d3 02800674
4 1c00003c 0e 1c001000  4 1c000040 0f cafef00d
4 1c000044 10 95fde01a  4 1c00004c 11 95fde01a
4 1c000050 12 0badc0de  4 1c000058 13 0badc0de
4 1c00005c 14 0badc0df
3 4
// beq and bne, taken and not taken
1 1c000060 0d
02800c15 02800c16 5c000ab6 58000eb6 029ffc17 029ff817 02815418
58000ab8 02800719 5c000eb9 0280041a 0280081a 0280433b
4 1c000060 15 00000003  4 1c000064 16 00000003
4 1c000078 18 00000055  4 1c000080 19 00000056
4 1c000090 1b 00000066
3 5
// writes to r0 are dropped, the last word branches to itself
1 1c000094 08
02848c00 0010001c 15ffffe0 0015541d 288011c0 02801c1e 0011781f 58000000
4 1c000098 1c 00000000  4 1c0000a0 1d 00000003
4 1c0000a8 1e 00000007  4 1c0000ac 1f fffffff9
0

/* filelist.f */
+incdir+.
cpu_pkg.sv
fetch_stage.sv
execute_stage.sv
writeback_stage.sv
regfile.sv
cpu_core_top.sv
trace_checker.sv
tb_cpu_core.sv
